//--- include/dmem_settings.svh
// Sizing macros for the data memory
// Byte capacity and the word-address width derived from it

`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// Total data memory capacity in bytes
`define DMEM_BYTES 1024

// Bits needed to address one 32-bit word, log2 of DMEM_BYTES / 4
`define DMEM_WORD_AW 8

`endif

//--- design/dmem_pkg.sv
// Types for the data memory array port
// Word type as four byte lanes and the memory request bundle

`include "dmem_settings.svh"

package dmem_pkg;

	// One memory word held as four bytes, index 0 is the low lane
	typedef logic [3:0][7:0] dmem_word_t;

	// Request bundle from the load/store unit into the memory array
	typedef struct packed {
		// Access strobe, the array only drives read data while this is high
		logic                     stb;
		// Write when high, read otherwise
		logic                     we;
		// One enable per byte lane, bit 0 covers bits 7:0 of the word
		logic [3:0]               byte_en;
		// Word index into the array
		logic [`DMEM_WORD_AW-1:0] word_addr;
		// Store data already shifted into its byte lanes
		logic [31:0]              wdata;
	} dmem_req_t;

endpackage

//--- design/lsu_pkg.sv
// Types for the core-side load/store interface
// Access opcode, fault code, request and response bundles

package lsu_pkg;

	// Top bit marks a store, the low three bits mirror the RISC-V funct3
	typedef enum logic [3:0] {
		LB  = 4'b0000,
		LH  = 4'b0001,
		LW  = 4'b0010,
		LBU = 4'b0100,
		LHU = 4'b0101,
		SB  = 4'b1000,
		SH  = 4'b1001,
		SW  = 4'b1010
	} lsu_op_e;

	// Reason an access was refused
	typedef enum logic [1:0] {
		FAULT_NONE       = 2'd0,
		FAULT_MISALIGNED = 2'd1,
		FAULT_RANGE      = 2'd2
	} lsu_fault_e;

	// One access from the core, valid is a single-cycle strobe
	typedef struct packed {
		logic        valid;
		lsu_op_e     op;
		logic [31:0] addr;
		logic [31:0] wdata;
	} lsu_req_t;

	// Answer to the core, returned one cycle after the request
	typedef struct packed {
		logic        valid;
		logic [31:0] rdata;
		lsu_fault_e  fault;
	} lsu_rsp_t;

endpackage

//--- design/data_mem.sv
// Byte-lane data memory
// Combinational little-endian word read and clocked byte-enabled write

`include "dmem_settings.svh"

module data_mem (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  dmem_pkg::dmem_req_t  i_mem,
	output logic [31:0]          o_rdata
);

	import dmem_pkg::*;

	// Number of words in the array
	localparam int unsigned NUM_WORDS = `DMEM_BYTES / 4;

	// Storage is a word array where every word is split into byte lanes
	// Lane 0 sits at the lowest byte address of the word
	dmem_word_t mem [0:NUM_WORDS-1];

	// Write qualifier shared by all lanes
	logic wr_en;

	// Word currently selected by the request
	dmem_word_t rd_word;

	// Writes need a strobe and the write flag
	// Nothing is written while reset is held low
	assign wr_en = i_mem.stb && i_mem.we && i_rst_n;

	// Read path has no clock and follows word_addr directly
	assign rd_word = mem[i_mem.word_addr];

	// Packed lanes already form the little-endian word
	// The bus reads back zero when the memory is not selected
	always_comb
	begin
		if (i_mem.stb)
		begin
			o_rdata = rd_word;
		end
		else
		begin
			o_rdata = 32'd0;
		end
	end

	// Each lane is written on its own so partial stores leave the
	// remaining bytes of the word untouched
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			for (int lane = 0; lane < 4; lane++)
			begin
				// Lane data was shifted into place by the load/store unit
				if (i_mem.byte_en[lane])
				begin
					mem[i_mem.word_addr][lane] <= i_mem.wdata[8*lane +: 8];
				end
			end
		end
	end

endmodule

//--- design/load_store_unit.sv
// Load/store unit in front of the data memory
// Opcode decode, alignment and range faults, store lane forming,
// load lane extraction with sign or zero extension, registered response

`include "dmem_settings.svh"

module load_store_unit (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  lsu_pkg::lsu_req_t    i_req,
	output dmem_pkg::dmem_req_t  o_mem,
	input  logic [31:0]          i_mem_rdata,
	output lsu_pkg::lsu_rsp_t    o_rsp
);

	import dmem_pkg::*;
	import lsu_pkg::*;

	// Decoded access properties
	logic        is_store;
	logic        is_byte;
	logic        is_half;
	logic        is_signed;
	logic [2:0]  acc_bytes;

	// Address one past the last byte touched, one bit wider to catch carry
	logic [32:0] acc_end;
	lsu_fault_e  fault;

	// Lane forming and extraction
	logic [3:0]  size_mask;
	logic [4:0]  lane_shift;
	logic [31:0] lane_rdata;
	logic [31:0] load_data;

	// Next response value
	lsu_rsp_t    rsp_d;

	// Size and signedness come straight from the opcode
	always_comb
	begin
		is_byte = 1'b0;
		is_half = 1'b0;
		case (i_req.op)
			LB, LBU, SB: is_byte = 1'b1;
			LH, LHU, SH: is_half = 1'b1;
			// Word accesses leave both flags low
			default: ;
		endcase
		is_store  = i_req.op inside {SB, SH, SW};
		is_signed = i_req.op inside {LB, LH};
		acc_bytes = is_byte ? 3'd1 : (is_half ? 3'd2 : 3'd4);
	end

	// Alignment is checked first and wins over the range check
	always_comb
	begin
		acc_end = {1'b0, i_req.addr} + {30'd0, acc_bytes};
		if ((is_half && i_req.addr[0])
			|| (!is_byte && !is_half && (i_req.addr[1:0] != 2'b00)))
		begin
			fault = FAULT_MISALIGNED;
		end
		else if (acc_end > 33'(`DMEM_BYTES))
		begin
			fault = FAULT_RANGE;
		end
		else
		begin
			fault = FAULT_NONE;
		end
	end

	// Low two address bits pick the starting lane
	assign lane_shift = {i_req.addr[1:0], 3'b000};
	assign size_mask  = is_byte ? 4'b0001 : (is_half ? 4'b0011 : 4'b1111);

	// Memory request, a faulting access never reaches the array
	always_comb
	begin
		o_mem.stb       = i_req.valid && (fault == FAULT_NONE);
		o_mem.we        = is_store;
		o_mem.byte_en   = o_mem.stb ? (size_mask << i_req.addr[1:0]) : 4'b0000;
		o_mem.word_addr = i_req.addr[`DMEM_WORD_AW+1:2];
		// Bits shifted past lane 3 are dropped, unused lanes are not enabled
		o_mem.wdata     = i_req.wdata << lane_shift;
	end

	// Move the addressed byte or halfword down to bit 0
	assign lane_rdata = i_mem_rdata >> lane_shift;

	// LB and LH copy the top bit up, LBU and LHU fill with zeros
	always_comb
	begin
		if (is_byte)
		begin
			load_data = {{24{is_signed & lane_rdata[7]}}, lane_rdata[7:0]};
		end
		else if (is_half)
		begin
			load_data = {{16{is_signed & lane_rdata[15]}}, lane_rdata[15:0]};
		end
		else
		begin
			load_data = lane_rdata;
		end
	end

	// Only a successful load returns data
	// Stores and faults answer with zero
	always_comb
	begin
		rsp_d.valid = i_req.valid;
		rsp_d.fault = i_req.valid ? fault : FAULT_NONE;
		rsp_d.rdata = (o_mem.stb && !is_store) ? load_data : 32'd0;
	end

	// Response appears one cycle after the request
	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_rsp <= '0;
		end
		else
		begin
			o_rsp <= rsp_d;
		end
	end

endmodule

//--- design/lsu_top.sv
// Data side top level
// Load/store unit driving the byte-lane data memory

module lsu_top (
	input  logic               clk,
	input  logic               i_rst_n,
	input  lsu_pkg::lsu_req_t  i_req,
	output lsu_pkg::lsu_rsp_t  o_rsp
);

	import dmem_pkg::*;

	// Request from the unit into the array
	dmem_req_t   mem_req;

	// Word read back in the same cycle
	logic [31:0] mem_rdata;

	// Decodes core accesses and registers the response
	load_store_unit i_load_store_unit (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_req       (i_req),
		.o_mem       (mem_req),
		.i_mem_rdata (mem_rdata),
		.o_rsp       (o_rsp)
	);

	// Storage with combinational read and clocked write
	data_mem i_data_mem (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_mem   (mem_req),
		.o_rdata (mem_rdata)
	);

endmodule

//--- verif/lsu_props.sv
// Concurrent checks bound into the load/store unit
// Response timing, reset state, fault data and memory strobe gating

`include "dmem_settings.svh"

module lsu_props (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  lsu_pkg::lsu_req_t    i_req,
	input  dmem_pkg::dmem_req_t  o_mem,
	input  lsu_pkg::lsu_rsp_t    o_rsp
);

	import lsu_pkg::*;

	// Independent view of the access size and of the two fault causes
	logic [2:0] acc_bytes;
	logic       misaligned;
	logic       out_of_range;

	// Number of assertion failures seen so far
	int unsigned fail_count = 0;

	// The low two opcode bits give the size, 0 for byte, 1 for half, 2 for word
	always_comb
	begin
		case (i_req.op[1:0])
			2'd0: acc_bytes = 3'd1;
			2'd1: acc_bytes = 3'd2;
			default: acc_bytes = 3'd4;
		endcase
		misaligned = ((acc_bytes == 3'd2) && i_req.addr[0])
			|| ((acc_bytes == 3'd4) && (i_req.addr[1:0] != 2'b00));
		out_of_range = ({1'b0, i_req.addr} + 33'(acc_bytes)) > 33'(`DMEM_BYTES);
	end

	// Every request is answered on the next edge
	a_rsp_follows_req: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_req.valid |=> o_rsp.valid)
		else
		begin
			fail_count++;
			$error("response missing one cycle after a request");
		end

	// And no response appears without a request
	a_no_rsp_without_req: assert property (@(posedge clk) disable iff (!i_rst_n)
		!i_req.valid |=> !o_rsp.valid)
		else
		begin
			fail_count++;
			$error("response pulse without a request");
		end

	a_rsp_low_in_reset: assert property (@(posedge clk)
		!i_rst_n |-> !o_rsp.valid)
		else
		begin
			fail_count++;
			$error("response valid while reset is asserted");
		end

	// A refused access never returns data
	a_fault_rdata_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
		(o_rsp.valid && (o_rsp.fault != FAULT_NONE)) |-> (o_rsp.rdata == 32'd0))
		else
		begin
			fail_count++;
			$error("fault response carries nonzero read data");
		end

	// The array is only touched by a legal, valid access
	a_stb_only_when_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_mem.stb |-> (i_req.valid && !misaligned && !out_of_range))
		else
		begin
			fail_count++;
			$error("memory strobe raised for an access that should fault");
		end

endmodule

//--- verif/tb_lsu_top.sv
// Testbench for the load/store unit and data memory top level
// Replays access vectors from the stimulus file and checks each response

module tb_lsu_top;

	import lsu_pkg::*;

	// Inputs change this long after the rising edge
	localparam int DRIVE_DLY = 1;
	// Cycles a response may take before the run is abandoned
	localparam int RSP_TIMEOUT = 4;

	logic        clk;
	logic        i_rst_n;
	lsu_req_t    i_req;
	lsu_rsp_t    o_rsp;

	// Fields of the current stimulus line
	integer      fd;
	integer      line_no;
	integer      n_fields;
	integer      gap;
	integer      exp_fault;
	string       line;
	string       op_name;
	string       test_name;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic [31:0] exp_rdata;
	lsu_op_e     op;
	bit          op_ok;

	lsu_top i_lsu_top (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_req   (i_req),
		.o_rsp   (o_rsp)
	);

	bind load_store_unit lsu_props i_lsu_props (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_req   (i_req),
		.o_mem   (o_mem),
		.o_rsp   (o_rsp)
	);

	// Free running clock, period of 8
	always #4 clk = ~clk;

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// Single comparison point for every checked value
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	// Advance to just after the next rising edge
	// A failed bound assertion ends the run here
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
		if (i_lsu_top.i_load_store_unit.i_lsu_props.fail_count != 0)
		begin
			stop_with_error("a bound assertion on the load/store unit failed");
		end
	endtask

	task automatic decode_op(input string name, output lsu_op_e code, output bit ok);
		ok = 1'b1;
		code = LB;
		case (name)
			"LB": code = LB;
			"LH": code = LH;
			"LW": code = LW;
			"LBU": code = LBU;
			"LHU": code = LHU;
			"SB": code = SB;
			"SH": code = SH;
			"SW": code = SW;
			default: ok = 1'b0;
		endcase
	endtask

	// One cycle without a request, no response may show up after it
	task automatic idle_cycle(input string name);
		i_req.valid = 1'b0;
		next_cycle();
		check_value({name, " idle valid"}, 32'd0, {31'd0, o_rsp.valid});
	endtask

	// Loop until the response pulse, dropping the request while waiting
	task automatic wait_response(input string name);
		int cycles;
		cycles = 0;
		while (!o_rsp.valid)
		begin
			if (cycles >= RSP_TIMEOUT)
			begin
				stop_with_error($sformatf("no response for %s within %0d cycles",
					name, RSP_TIMEOUT));
			end
			i_req.valid = 1'b0;
			next_cycle();
			cycles++;
		end
	endtask

	// Issue one access after the given idle gap and check its answer
	task automatic run_access(input string name, input integer idle,
		input lsu_op_e code, input logic [31:0] a, input logic [31:0] d,
		input logic [31:0] rdata, input integer fault);
		repeat (idle) idle_cycle(name);
		i_req.valid = 1'b1;
		i_req.op    = code;
		i_req.addr  = a;
		i_req.wdata = d;
		next_cycle();
		wait_response(name);
		check_value({name, " rdata"}, rdata, o_rsp.rdata);
		check_value({name, " fault"}, 32'(fault), {30'd0, o_rsp.fault});
	endtask

	initial
	begin
		clk     = 1'b0;
		i_rst_n = 1'b1;
		i_req   = '0;
		// Reset falls just after time zero so the async clear always fires
		#DRIVE_DLY;
		i_rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#DRIVE_DLY;
		i_rst_n = 1'b1;

		fd = $fopen("verif/lsu_stim.txt", "r");
		if (fd == 0)
		begin
			stop_with_error("cannot open the stimulus file verif/lsu_stim.txt");
		end
		line_no = 0;
		while (!$feof(fd))
		begin
			line = "";
			n_fields = $fgets(line, fd);
			line_no++;
			// Blank lines and lines starting with a hash carry no access
			if ((n_fields > 0) && (line.len() > 1) && (line[0] != "#"))
			begin
				test_name = $sformatf("line %0d", line_no);
				n_fields = $sscanf(line, "%d %s %h %h %h %d", gap, op_name, addr,
					wdata, exp_rdata, exp_fault);
				if (n_fields != 6)
				begin
					stop_with_error($sformatf("malformed stimulus at %s", test_name));
				end
				decode_op(op_name, op, op_ok);
				if (!op_ok)
				begin
					stop_with_error($sformatf("unknown opcode %s at %s", op_name,
						test_name));
				end
				run_access(test_name, gap, op, addr, wdata, exp_rdata, exp_fault);
			end
		end
		$fclose(fd);

		// The last response must be a single pulse
		idle_cycle("end of stimulus");
		$display("Test OK");
		$finish;
	end

endmodule

//--- sources.f
+incdir+include
design/dmem_pkg.sv
design/lsu_pkg.sv
design/data_mem.sv
design/load_store_unit.sv
design/lsu_top.sv
verif/lsu_props.sv
verif/tb_lsu_top.sv

//--- Bender.yml
package:
  name: lsu_top

export_include_dirs:
  - include

sources:
  - design/dmem_pkg.sv
  - design/lsu_pkg.sv
  - design/data_mem.sv
  - design/load_store_unit.sv
  - design/lsu_top.sv
  - target: simulation
    files:
      - verif/lsu_props.sv
      - verif/tb_lsu_top.sv

//--- verif/lsu_stim.txt
# gap op addr wdata exp_rdata exp_fault, gap is idle cycles before the access
# addr, wdata and rdata in hex, fault 0 none, 1 misaligned, 2 out of range
2 SW  000 11223344 00000000 0
0 LW  000 00000000 11223344 0
1 SW  004 a5b6c7d8 00000000 0
0 SB  005 000000e1 00000000 0
0 SH  006 00007f02 00000000 0
0 LW  004 00000000 7f02e1d8 0
0 LB  004 00000000 ffffffd8 0
0 LBU 004 00000000 000000d8 0
0 LB  007 00000000 0000007f 0
0 LBU 006 00000000 00000002 0
0 LB  005 00000000 ffffffe1 0
0 LH  004 00000000 ffffe1d8 0
0 LHU 004 00000000 0000e1d8 0
0 LH  006 00000000 00007f02 0
0 LHU 006 00000000 00007f02 0
1 SW  3fc cafef00d 00000000 0
0 LW  3fc 00000000 cafef00d 0
0 LH  3fe 00000000 ffffcafe 0
0 SH  001 0000beef 00000000 1
0 LH  003 00000000 00000000 1
0 SW  002 deadbeef 00000000 1
0 LW  006 00000000 00000000 1
0 SW  400 12345678 00000000 2
0 LHU 3ff 00000000 00000000 1
0 LB  400 00000000 00000000 2
0 SB  7fc 00000055 00000000 2
1 LW  000 00000000 11223344 0
0 LW  3fc 00000000 cafef00d 0
0 LW  004 00000000 7f02e1d8 0
